//--- qspi_pkg.sv
// --------------------
// Shared definitions for the serial flash controller
// Command word union and header layout
// Sequence codes
// Sizing constants
// --------------------
`default_nettype none

package qspi_pkg;

  // --------------------
  // Sizing
  // --------------------
  localparam int NUM_CS          = 4;
  // Clk cycles of csn low before first and after last SCK edge
  localparam int CS_GUARD_CYCLES = 2;
  localparam int GUARD_W         = $clog2(CS_GUARD_CYCLES + 1);
  // Per-word bit count, 1 to 32
  localparam int BITS_W          = 6;
  localparam int DIV_W           = 8;

  typedef logic [31:0] word_t;
  typedef logic [3:0]  seq_t;

  // --------------------
  // Sequence codes
  // --------------------
  localparam seq_t SEQ_C   = 4'd0;
  localparam seq_t SEQ_CW  = 4'd1;
  localparam seq_t SEQ_CA  = 4'd2;
  localparam seq_t SEQ_CAR = 4'd3;
  localparam seq_t SEQ_CAW = 4'd7;
  localparam seq_t SEQ_CR  = 4'd12;

  // Header view, first word of every command
  typedef struct packed {
    logic [7:0] data_bytes;
    // 0..3 means 1..4 address bytes
    logic [1:0] addr_len;
    seq_t       seq;
    // Active high here, inverted onto csn
    logic [3:0] cs_mask;
    logic [7:0] opcode;
    logic [5:0] pad;
  } cmd_hdr_t;

  // Same buffer entry seen as header or as address/data payload
  typedef union packed {
    cmd_hdr_t hdr;
    word_t    raw;
  } cmd_word_u;

endpackage

`default_nettype wire

//--- qspi_shift_if.sv
// --------------------
// Sequencer to shift engine transfer bus
// Modports for both sides
// --------------------
`default_nettype none

interface qspi_shift_if;
  import qspi_pkg::*;

  // One-cycle request, only while engine is idle
  logic              start;
  // Read transfer, sdo held low
  logic              read;
  logic [BITS_W-1:0] nbits;
  // Left aligned, bit 31 goes out first
  word_t             tx_word;
  // One-cycle pulse after last bit, rx_word valid with it
  logic              done;
  word_t             rx_word;

  modport sequencer (output start, read, nbits, tx_word, input done, rx_word);
  modport shifter   (input start, read, nbits, tx_word, output done, rx_word);

endinterface

`default_nettype wire

//--- qspi_fifo.sv
// --------------------
// Synchronous word FIFO
// Circular buffer, show-ahead head output
// --------------------
`default_nettype none

module qspi_fifo #(
  parameter int DEPTH = 4
) (
  input  logic            clk,
  input  logic            rstn,
  input  logic            push,
  input  qspi_pkg::word_t push_data,
  input  logic            pop,
  output qspi_pkg::word_t head,
  output logic            empty,
  output logic            full
);
  import qspi_pkg::*;

  word_t                  mem [DEPTH];
  logic [$clog2(DEPTH)-1:0] wr_ptr;
  logic [$clog2(DEPTH)-1:0] rd_ptr;
  // One extra bit so that DEPTH itself fits
  logic [$clog2(DEPTH):0]   count;

  // Head is visible as soon as it is written
  assign head  = mem[rd_ptr];
  assign empty = (count == '0);
  // DEPTH is a power of two, MSB set only when full
  assign full  = count[$clog2(DEPTH)];

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // Pointers wrap naturally
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Storage
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  a_no_overflow: assert property (@(posedge clk) disable iff (!rstn) full |-> !push)
    else $error("push into a full FIFO");
  a_no_underflow: assert property (@(posedge clk) disable iff (!rstn) empty |-> !pop)
    else $error("pop from an empty FIFO");

endmodule

`default_nettype wire

//--- qspi_clkgen.sv
// --------------------
// SCK divider
// Half period of sck_div+1 clk cycles
// One-cycle rise and fall strobes
// --------------------
`default_nettype none

module qspi_clkgen (
  input  logic                       clk,
  input  logic                       rstn,
  input  logic                       en,
  input  logic [qspi_pkg::DIV_W-1:0] sck_div,
  output logic                       sck,
  output logic                       rise,
  output logic                       fall
);
  import qspi_pkg::*;

  logic [DIV_W-1:0] cnt;
  logic             run;

  // Keep going while high so SCK always parks low
  assign run = en | sck;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      cnt  <= '0;
      sck  <= 1'b0;
      rise <= 1'b0;
      fall <= 1'b0;
    end else begin
      rise <= 1'b0;
      fall <= 1'b0;
      if (!run) begin
        // Stopped, full half period before the next rise
        cnt <= sck_div;
      end else if (cnt == '0) begin
        cnt  <= sck_div;
        sck  <= ~sck;
        // Strobes line up with the new sck level
        rise <= ~sck;
        fall <= sck;
      end else begin
        cnt <= cnt - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- qspi_shift_engine.sv
// --------------------
// Bit-serial shift engine, SPI mode 0
// Transmit on fall, sample on rise
// Bit counter and done pulse
// --------------------
`default_nettype none

module qspi_shift_engine (
  input  logic                 clk,
  input  logic                 rstn,
  qspi_shift_if.shifter        shift,
  input  logic                 rise,
  input  logic                 fall,
  input  logic                 sdi,
  output logic                 clk_en,
  output logic                 sdo
);
  import qspi_pkg::*;

  logic              busy;
  // Bits still to be sampled
  logic [BITS_W-1:0] bits_left;
  logic              read_q;
  word_t             tx_sr;
  word_t             rx_sr;
  logic              last_fall;

  // Fall after the final rise closes the transfer
  assign last_fall = busy && fall && (bits_left == '0);

  // Drop enable in that same cycle so no extra SCK edge slips out
  assign clk_en = busy && !last_fall;

  assign shift.rx_word = rx_sr;

  // --------------------
  // Control
  // --------------------
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      busy       <= 1'b0;
      bits_left  <= '0;
      shift.done <= 1'b0;
      sdo        <= 1'b0;
    end else begin
      shift.done <= 1'b0;
      if (shift.start) begin
        busy      <= 1'b1;
        bits_left <= shift.nbits;
        // First bit must be on the line before the first rise
        sdo       <= shift.read ? 1'b0 : shift.tx_word[31];
      end else if (busy) begin
        if (rise) begin
          bits_left <= bits_left - 1'b1;
        end
        if (last_fall) begin
          busy       <= 1'b0;
          shift.done <= 1'b1;
          sdo        <= 1'b0;
        end else if (fall) begin
          sdo <= read_q ? 1'b0 : tx_sr[30];
        end
      end
    end
  end

  // --------------------
  // Shift registers
  // --------------------
  always_ff @(posedge clk) begin
    if (shift.start) begin
      tx_sr  <= shift.tx_word;
      read_q <= shift.read;
    end else if (busy && fall) begin
      tx_sr <= tx_sr << 1;
    end
    // MSB first, oldest bit ends up highest
    if (busy && rise) begin
      rx_sr <= {rx_sr[30:0], sdi};
    end
  end

  // Sequencer must wait for done before the next start
  a_start_idle: assert property (@(posedge clk) disable iff (!rstn) shift.start |-> !busy)
    else $error("transfer start while engine busy");

endmodule

`default_nettype wire

//--- qspi_sequencer.sv
// --------------------
// Transaction FSM
// Header latch and sequence decode
// Byte ordering of address and data words
// Chip-select control with guard time
// --------------------
`default_nettype none

module qspi_sequencer (
  input  logic                        clk,
  input  logic                        rstn,
  input  logic                        cmd_empty,
  input  qspi_pkg::word_t             cmd_head,
  output logic                        cmd_pop,
  input  logic                        rsp_full,
  output logic                        rsp_push,
  output qspi_pkg::word_t             rsp_word,
  qspi_shift_if.sequencer             shift,
  output logic [qspi_pkg::NUM_CS-1:0] csn
);
  import qspi_pkg::*;

  typedef enum logic [2:0] {
    S_IDLE, S_GUARD, S_OPCODE, S_ADDR, S_WRITE, S_READ, S_RELEASE
  } state_t;

  state_t             state;
  state_t             data_state;
  cmd_word_u          head_u;
  cmd_hdr_t           hdr;
  logic [7:0]         bytes_left;
  logic [2:0]         cur_bytes;
  logic [2:0]         word_bytes;
  logic [1:0]         wb_m1;
  logic [GUARD_W-1:0] guard_cnt;
  logic               inflight;
  logic               has_addr;
  logic               has_write;
  logic               has_read;
  logic               launch;
  logic               pop_word;
  logic               read_d;
  logic [BITS_W-1:0]  nbits_d;
  word_t              tx_d;

  // Byte 0 first on the wire, engine sends bit 31 first
  function automatic word_t bswap(input word_t w);
    return {w[7:0], w[15:8], w[23:16], w[31:24]};
  endfunction

  assign head_u = cmd_head;

  // Unknown codes fall back to command only
  assign has_addr  = hdr.seq inside {SEQ_CA, SEQ_CAR, SEQ_CAW};
  assign has_write = hdr.seq inside {SEQ_CW, SEQ_CAW};
  assign has_read  = hdr.seq inside {SEQ_CAR, SEQ_CR};

  // Up to four bytes per word
  assign cur_bytes = (bytes_left > 8'd4) ? 3'd4 : bytes_left[2:0];
  assign wb_m1     = 2'(word_bytes - 3'd1);

  // Phase after opcode or address
  always_comb begin
    data_state = S_RELEASE;
    if (has_write && hdr.data_bytes != '0) begin
      data_state = S_WRITE;
    end else if (has_read && hdr.data_bytes != '0) begin
      data_state = S_READ;
    end
  end

  // --------------------
  // Transfer launch
  // --------------------
  always_comb begin
    launch   = 1'b0;
    pop_word = 1'b0;
    read_d   = 1'b0;
    nbits_d  = '0;
    tx_d     = '0;
    if (!inflight) begin
      case (state)
        S_OPCODE: begin
          launch  = 1'b1;
          nbits_d = 6'd8;
          tx_d    = {hdr.opcode, 24'h0};
        end
        // Low addr_len+1 bytes, moved up to bit 31
        S_ADDR: if (!cmd_empty) begin
          launch   = 1'b1;
          pop_word = 1'b1;
          nbits_d  = {({1'b0, hdr.addr_len} + 3'd1), 3'b000};
          tx_d     = head_u.raw << {~hdr.addr_len, 3'b000};
        end
        // Word popped as the engine takes it
        S_WRITE: if (!cmd_empty) begin
          launch   = 1'b1;
          pop_word = 1'b1;
          nbits_d  = {cur_bytes, 3'b000};
          tx_d     = bswap(head_u.raw);
        end
        // Back-pressure holds the next read word
        S_READ: if (!rsp_full) begin
          launch  = 1'b1;
          read_d  = 1'b1;
          nbits_d = {cur_bytes, 3'b000};
        end
        default: launch = 1'b0;
      endcase
    end
  end

  assign cmd_pop  = ((state == S_IDLE) && !cmd_empty) || pop_word;

  // Received bytes sit low, align to top then swap so byte 0 lands in bits 7..0
  assign rsp_push = (state == S_READ) && shift.done;
  assign rsp_word = bswap(shift.rx_word << {~wb_m1, 3'b000});

  // --------------------
  // State and chip select
  // --------------------
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state       <= S_IDLE;
      csn         <= '1;
      inflight    <= 1'b0;
      guard_cnt   <= '0;
      bytes_left  <= '0;
      shift.start <= 1'b0;
    end else begin
      shift.start <= launch;
      if (launch) begin
        inflight <= 1'b1;
      end else if (shift.done) begin
        inflight <= 1'b0;
      end
      if (launch && (state == S_WRITE || state == S_READ)) begin
        bytes_left <= bytes_left - 8'(cur_bytes);
      end
      guard_cnt <= '0;
      case (state)
        S_IDLE: if (!cmd_empty) begin
          csn        <= ~head_u.hdr.cs_mask;
          bytes_left <= head_u.hdr.data_bytes;
          state      <= S_GUARD;
        end
        S_GUARD: begin
          guard_cnt <= guard_cnt + 1'b1;
          if (guard_cnt == GUARD_W'(CS_GUARD_CYCLES - 1)) begin
            state <= S_OPCODE;
          end
        end
        S_OPCODE: if (shift.done) begin
          state <= has_addr ? S_ADDR : data_state;
        end
        S_ADDR: if (shift.done) begin
          state <= data_state;
        end
        S_WRITE, S_READ: if (shift.done && bytes_left == '0) begin
          state <= S_RELEASE;
        end
        S_RELEASE: begin
          guard_cnt <= guard_cnt + 1'b1;
          if (guard_cnt == GUARD_W'(CS_GUARD_CYCLES - 1)) begin
            csn   <= '1;
            state <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // Header and transfer payload
  always_ff @(posedge clk) begin
    if (state == S_IDLE && !cmd_empty) begin
      hdr <= head_u.hdr;
    end
    if (launch) begin
      shift.read    <= read_d;
      shift.nbits   <= nbits_d;
      shift.tx_word <= tx_d;
      word_bytes    <= cur_bytes;
    end
  end

  a_idle_csn: assert property (@(posedge clk) disable iff (!rstn) state == S_IDLE |-> csn == '1)
    else $error("chip select low while idle");
  a_rsp_room: assert property (@(posedge clk) disable iff (!rstn) rsp_push |-> !rsp_full)
    else $error("response push into a full FIFO");

endmodule

`default_nettype wire

//--- qspi_master.sv
// --------------------
// Serial flash controller top level
// Command and response FIFOs, sequencer,
// shift engine and SCK generator
// --------------------
`default_nettype none

module qspi_master (
  input  logic                        clk,
  input  logic                        rstn,
  input  logic [qspi_pkg::DIV_W-1:0]  sck_div,
  // Command stream
  input  logic                        cmd_valid,
  output logic                        cmd_ready,
  input  logic [31:0]                 cmd_data,
  // Response stream
  output logic                        rsp_valid,
  input  logic                        rsp_ready,
  output logic [31:0]                 rsp_data,
  // SPI pins
  output logic                        sck,
  output logic [qspi_pkg::NUM_CS-1:0] csn,
  output logic                        sdo,
  input  logic                        sdi
);
  import qspi_pkg::*;

  logic  cmd_full;
  logic  cmd_empty;
  logic  cmd_pop;
  word_t cmd_head;
  logic  rsp_full;
  logic  rsp_empty;
  logic  rsp_push;
  word_t rsp_word;
  logic  clk_en;
  logic  rise;
  logic  fall;

  qspi_shift_if shift_bus ();

  // Stream handshakes map straight onto FIFO flags
  assign cmd_ready = ~cmd_full;
  assign rsp_valid = ~rsp_empty;

  qspi_fifo u_cmd_fifo (
    .clk       (clk),
    .rstn      (rstn),
    .push      (cmd_valid & ~cmd_full),
    .push_data (cmd_data),
    .pop       (cmd_pop),
    .head      (cmd_head),
    .empty     (cmd_empty),
    .full      (cmd_full)
  );

  qspi_fifo u_rsp_fifo (
    .clk       (clk),
    .rstn      (rstn),
    .push      (rsp_push),
    .push_data (rsp_word),
    .pop       (rsp_ready & ~rsp_empty),
    .head      (rsp_data),
    .empty     (rsp_empty),
    .full      (rsp_full)
  );

  qspi_sequencer u_sequencer (
    .clk       (clk),
    .rstn      (rstn),
    .cmd_empty (cmd_empty),
    .cmd_head  (cmd_head),
    .cmd_pop   (cmd_pop),
    .rsp_full  (rsp_full),
    .rsp_push  (rsp_push),
    .rsp_word  (rsp_word),
    .shift     (shift_bus.sequencer),
    .csn       (csn)
  );

  qspi_shift_engine u_engine (
    .clk    (clk),
    .rstn   (rstn),
    .shift  (shift_bus.shifter),
    .rise   (rise),
    .fall   (fall),
    .sdi    (sdi),
    .clk_en (clk_en),
    .sdo    (sdo)
  );

  qspi_clkgen u_clkgen (
    .clk     (clk),
    .rstn    (rstn),
    .en      (clk_en),
    .sck_div (sck_div),
    .sck     (sck),
    .rise    (rise),
    .fall    (fall)
  );

endmodule

`default_nettype wire

//--- tb_qspi_master.sv
// --------------------
// Testbench for the serial flash controller
// Transaction table applied in a loop
// SPI slave model, Galois LFSR, checks
// --------------------
`default_nettype none

module tb_qspi_master;
  timeunit 1ns;
  timeprecision 100ps;
  import qspi_pkg::*;

  localparam int TIMEOUT   = 20000;
  localparam int N_ENTRIES = 10;

  // seq, addr_len, data_bytes, cs_mask, opcode, address, write-data seed
  typedef struct packed {
    logic [3:0]  seq;
    logic [1:0]  al;
    logic [7:0]  db;
    logic [3:0]  mask;
    logic [7:0]  op;
    logic [31:0] addr;
    logic [31:0] seed;
  } entry_t;

  entry_t tbl [N_ENTRIES] = '{
    '{SEQ_C,   2'd0, 8'd0,  4'b0001, 8'h06, 32'h0000_0000, 32'h0000_0000},
    '{SEQ_CA,  2'd0, 8'd0,  4'b0010, 8'hd8, 32'h0000_00a5, 32'h0000_0000},
    '{SEQ_CA,  2'd3, 8'd0,  4'b0100, 8'h20, 32'h1234_5678, 32'h0000_0000},
    '{SEQ_CAW, 2'd2, 8'd4,  4'b0001, 8'h02, 32'h00ab_cdef, 32'h0000_1111},
    '{SEQ_CW,  2'd0, 8'd7,  4'b1000, 8'h9a, 32'h0000_0000, 32'h2222_0000},
    '{SEQ_CAR, 2'd2, 8'd4,  4'b0001, 8'h03, 32'h0001_0203, 32'h0000_0000},
    '{SEQ_CR,  2'd0, 8'd6,  4'b0010, 8'h9f, 32'h0000_0000, 32'h0000_0000},
    '{SEQ_CAR, 2'd2, 8'd24, 4'b0001, 8'h0b, 32'h0004_0000, 32'h0000_0000},
    '{SEQ_CAW, 2'd1, 8'd5,  4'b0100, 8'h32, 32'h0000_beef, 32'h5a5a_a5a5},
    '{SEQ_CAR, 2'd3, 8'd3,  4'b1000, 8'h13, 32'hcafe_0001, 32'h0000_0000}
  };

  logic              clk;
  logic              rstn;
  logic [DIV_W-1:0]  sck_div;
  logic              cmd_valid;
  logic              cmd_ready;
  logic [31:0]       cmd_data;
  logic              rsp_valid;
  logic              rsp_ready;
  logic [31:0]       rsp_data;
  logic              sck;
  logic [NUM_CS-1:0] csn;
  logic              sdo;
  logic              sdi;

  int          errors;
  int          tests;
  int          failed_tests;
  int          err_start;
  logic [31:0] wr_lfsr = 32'h022b_e9af;
  logic [31:0] rd_lfsr = 32'h022b_e9af;

  // Expected and observed traffic of the running test
  logic [7:0]        exp_tx [$];
  logic [7:0]        got_tx [$];
  logic [NUM_CS-1:0] exp_csn [$];
  logic [NUM_CS-1:0] got_csn [$];
  logic [31:0]       got_rsp [$];
  logic              rx_bits [$];
  int                tx_plan [$];
  int                rd_lens [$];
  int                exp_rises;
  int                rises_total;
  int                rises_win;
  int                cur_tx_bits;
  int                win_ends;
  bit                in_win;
  logic [7:0]        sh_byte;

  qspi_master i_dut (
    .clk       (clk),
    .rstn      (rstn),
    .sck_div   (sck_div),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .cmd_data  (cmd_data),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp_data  (rsp_data),
    .sck       (sck),
    .csn       (csn),
    .sdo       (sdo),
    .sdi       (sdi)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // x^32 + x^22 + x^2 + x + 1, right shifting
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic rand_word(output logic [31:0] w);
    w = '0;
    for (int i = 0; i < 32; i++) begin
      w       = {w[30:0], wr_lfsr[0]};
      wr_lfsr = lfsr_next(wr_lfsr);
    end
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  // --------------------
  // SPI slave model
  // --------------------
  // Opening and closing of a csn-low window
  always @(posedge clk) begin
    if (!in_win && rstn && csn != '1) begin
      in_win    = 1'b1;
      rises_win = 0;
      got_csn.push_back(csn);
      assert (tx_plan.size() > 0) else begin
        $display("Chip select went low with no command queued at %0t", $time);
        errors++;
      end
      cur_tx_bits = (tx_plan.size() > 0) ? tx_plan.pop_front() : 0;
    end else if (in_win && csn == '1) begin
      in_win = 1'b0;
      win_ends++;
    end
    if (rsp_valid && rsp_ready) begin
      got_rsp.push_back(rsp_data);
    end
  end

  // Capture sdo during transmit, record sdi as sampled during read
  always @(posedge sck) begin
    if (in_win) begin
      rises_total++;
      if (rises_win < cur_tx_bits) begin
        sh_byte = {sh_byte[6:0], sdo};
        if (rises_win % 8 == 7) begin
          got_tx.push_back(sh_byte);
        end
      end else begin
        rx_bits.push_back(sdi);
      end
      rises_win++;
    end
  end

  // Read data changes on the falling edge
  always @(negedge sck) begin
    if (in_win && rises_win >= cur_tx_bits) begin
      #10;
      sdi     = rd_lfsr[0];
      rd_lfsr = lfsr_next(rd_lfsr);
    end
  end

  // --------------------
  // Stimulus
  // --------------------
  task automatic send_word(input logic [31:0] w);
    int  n;
    bit  ok;
    cmd_valid = 1'b1;
    cmd_data  = w;
    n         = 0;
    do begin
      @(posedge clk);
      ok = cmd_ready;
      n++;
    end while (!ok && n < TIMEOUT);
    assert (ok) else begin
      $display("Timeout waiting for the command stream to accept a word");
      errors++;
    end
    #10;
    cmd_valid = 1'b0;
  endtask

  // Expected wire bytes and responses follow from the table
  task automatic queue_entry(input int i);
    entry_t      e;
    logic [31:0] hdr;
    logic [31:0] w;
    logic [31:0] words [$];
    int          nb;
    bit          has_a;
    bit          has_w;
    bit          has_r;
    e     = tbl[i];
    has_a = e.seq inside {SEQ_CA, SEQ_CAR, SEQ_CAW};
    has_w = e.seq inside {SEQ_CW, SEQ_CAW};
    has_r = e.seq inside {SEQ_CAR, SEQ_CR};
    hdr   = {e.db, e.al, e.seq, e.mask, e.op, 6'd0};
    exp_tx.push_back(e.op);
    nb = 1;
    if (has_a) begin
      for (int b = int'(e.al); b >= 0; b--) begin
        exp_tx.push_back(e.addr[8*b +: 8]);
      end
      nb += int'(e.al) + 1;
    end
    if (has_w) begin
      for (int wi = 0; wi < (int'(e.db) + 3) / 4; wi++) begin
        rand_word(w);
        w = w ^ e.seed;
        words.push_back(w);
        for (int k = 0; k < 4; k++) begin
          if (4 * wi + k < int'(e.db)) begin
            exp_tx.push_back(w[8*k +: 8]);
          end
        end
      end
      nb += int'(e.db);
    end
    tx_plan.push_back(8 * nb);
    exp_csn.push_back(~e.mask);
    exp_rises += 8 * nb;
    if (has_r && e.db != 0) begin
      rd_lens.push_back(int'(e.db));
      exp_rises += 8 * int'(e.db);
    end
    send_word(hdr);
    if (has_a) begin
      send_word(e.addr);
    end
    foreach (words[j]) begin
      send_word(words[j]);
    end
  endtask

  task automatic wait_window_ends(input int target);
    int n;
    n = 0;
    while (win_ends < target && n < TIMEOUT) begin
      @(posedge clk);
      n++;
    end
    assert (win_ends >= target) else begin
      $display("Timeout waiting for chip select to return high");
      errors++;
    end
    #10;
  endtask

  task automatic wait_responses();
    int n;
    int cnt;
    cnt = 0;
    foreach (rd_lens[j]) begin
      cnt += (rd_lens[j] + 3) / 4;
    end
    n = 0;
    while (got_rsp.size() < cnt && n < TIMEOUT) begin
      @(posedge clk);
      n++;
    end
    assert (got_rsp.size() >= cnt) else begin
      $display("Timeout waiting for response words");
      errors++;
    end
    // Room for any stray extra word to show up
    repeat (4) @(posedge clk);
    #10;
  endtask

  task automatic begin_test();
    exp_tx.delete();
    got_tx.delete();
    exp_csn.delete();
    got_csn.delete();
    got_rsp.delete();
    rx_bits.delete();
    rd_lens.delete();
    exp_rises   = 0;
    rises_total = 0;
    win_ends    = 0;
    err_start   = errors;
  endtask

  task automatic end_test(input string name);
    logic [31:0] exp_rsp [$];
    logic [31:0] w;
    int          idx;
    // Read bytes packed little-endian, each byte MSB first on the wire
    idx = 0;
    foreach (rd_lens[j]) begin
      for (int wi = 0; wi < (rd_lens[j] + 3) / 4; wi++) begin
        w = '0;
        for (int k = 0; k < 4 && 4 * wi + k < rd_lens[j]; k++) begin
          for (int b = 0; b < 8; b++) begin
            w[8*k + 7 - b] = (idx < rx_bits.size()) ? rx_bits[idx] : 1'bx;
            idx++;
          end
        end
        exp_rsp.push_back(w);
      end
    end
    check_val("tx byte count", got_tx.size(), exp_tx.size());
    foreach (exp_tx[j]) begin
      if (j < got_tx.size()) check_val($sformatf("sdo byte %0d", j), got_tx[j], exp_tx[j]);
    end
    check_val("csn window count", got_csn.size(), exp_csn.size());
    foreach (exp_csn[j]) begin
      if (j < got_csn.size()) check_val($sformatf("csn window %0d", j), got_csn[j], exp_csn[j]);
    end
    check_val("sck rises", rises_total, exp_rises);
    check_val("rsp word count", got_rsp.size(), exp_rsp.size());
    foreach (exp_rsp[j]) begin
      if (j < got_rsp.size()) check_val($sformatf("rsp_data %0d", j), got_rsp[j], exp_rsp[j]);
    end
    tests++;
    if (errors > err_start) failed_tests++;
    $display("test %s: %s", name, (errors > err_start) ? "errors" : "ok");
  endtask

  // --------------------
  // Test sequence
  // --------------------
  initial begin
    int idle;
    int n;
    logic last_sck;
    errors       = 0;
    tests        = 0;
    failed_tests = 0;
    rstn         = 1'b0;
    sck_div      = 8'd1;
    cmd_valid    = 1'b0;
    cmd_data     = '0;
    rsp_ready    = 1'b1;
    sdi          = 1'b0;
    in_win       = 1'b0;
    win_ends     = 0;
    repeat (4) @(posedge clk);
    #10;
    rstn = 1'b1;

    begin_test();
    check_val("csn", csn, {NUM_CS{1'b1}});
    check_val("sck", sck, 0);
    check_val("sdo", sdo, 0);
    check_val("rsp_valid", rsp_valid, 0);
    check_val("cmd_ready", cmd_ready, 1);
    tests++;
    if (errors > err_start) failed_tests++;
    $display("test reset: %s", (errors > err_start) ? "errors" : "ok");

    // Single commands, one per table row
    for (int i = 0; i < 7; i++) begin
      begin_test();
      queue_entry(i);
      wait_window_ends(1);
      wait_responses();
      end_test($sformatf("entry %0d", i));
    end

    // Long read against a stalled response stream
    begin_test();
    rsp_ready = 1'b0;
    queue_entry(7);
    idle     = 0;
    n        = 0;
    last_sck = sck;
    while ((!in_win || idle < 40) && n < TIMEOUT) begin
      @(posedge clk);
      idle     = (sck == last_sck) ? idle + 1 : 0;
      last_sck = sck;
      n++;
    end
    assert (idle >= 40) else begin
      $display("Timeout waiting for sck to stop under back-pressure");
      errors++;
    end
    check_val("csn during stall", csn, 4'b1110);
    #10;
    rsp_ready = 1'b1;
    wait_window_ends(1);
    wait_responses();
    end_test("read stall");

    // Second command queued while the first one runs
    begin_test();
    queue_entry(8);
    queue_entry(9);
    wait_window_ends(2);
    wait_responses();
    end_test("back to back");

    $display("%0d tests, %0d failed, %0d check errors", tests, failed_tests, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
qspi_pkg.sv
qspi_shift_if.sv
qspi_fifo.sv
qspi_clkgen.sv
qspi_shift_engine.sv
qspi_sequencer.sv
qspi_master.sv
tb_qspi_master.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_qspi_master
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FILELIST  ?= filelist.f

SRCS := $(shell cat $(FILELIST))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee /dev/stderr | grep -q "^Test passed$$"

clean:
	rm -rf $(BUILD_DIR)
